/* filelist.f */
+incdir+logic
logic/capture_pkg.sv
logic/sample_packer.sv
logic/beat_fifo.sv
logic/axi_burst_writer.sv
logic/capture_top.sv
tests/tb_capture_top.sv

/* Makefile */
TOP = tb_capture_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f filelist.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* tests/tb_capture_top.sv */
`timescale 1ns/1ps
`include "capture_consts.svh"

module tb_capture_top;

  localparam int BEAT_BYTES  = `CAP_BEAT_W / 8;
  localparam int BURST_BYTES = `CAP_BURST_LEN * BEAT_BYTES;
  localparam int OVF_BEATS   = 40;

  logic                     clk;
  logic                     rst_n;
  logic                     sample_valid;
  logic [`CAP_SAMPLE_W-1:0] sample_data;
  logic                     awvalid;
  logic [`CAP_ADDR_W-1:0]   awaddr;
  logic                     awready;
  logic                     wvalid;
  logic                     wlast;
  logic [`CAP_BEAT_W-1:0]   wdata;
  logic                     wready;
  logic                     bvalid;
  logic [1:0]               bresp;
  logic                     bready;
  logic                     done;
  logic                     resp_err;
  logic                     overflow;

  // stimulus control
  int send_mode;
  logic hold_w;
  int err_burst;
  logic [31:0] lcg_state;

  // reference model and slave memory
  logic [`CAP_BEAT_W-1:0] exp_q [$];
  logic [`CAP_BEAT_W-1:0] kept_q [$];
  logic [`CAP_BEAT_W-1:0] mem [logic [`CAP_ADDR_W-1:0]];
  logic [`CAP_BEAT_W-1:0] part_beat;
  logic [`CAP_BEAT_W-1:0] pend_beat;
  logic [`CAP_ADDR_W-1:0] exp_addr;
  logic [`CAP_ADDR_W-1:0] cur_addr;
  int lane;
  int fifo_cnt;
  int beat_idx;
  int beats_written;
  int bursts_done;
  int drops;
  int b_delay;
  logic push_next;
  logic burst_open;
  logic b_pending;
  logic b_seen;
  logic done_exp;
  logic err_exp;
  logic ovf_exp;
  int errors;
  int tests_run;
  int tests_failed;

  capture_top u_capture_top (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    // halves swapped since the low bits of an LCG are weak
    return {lcg_state[15:0], lcg_state[31:16]};
  endfunction

  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      $display("ERR %s got=%0h exp=%0h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  task automatic report(input string msg);
    $display("error: %s at %0t", msg, $time);
    errors++;
  endtask

  task automatic finish_test(input string name, input int start_errs);
    int n;
    n = errors - start_errs;
    tests_run++;
    if (n == 0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, n);
    end
  endtask

  // **********************************************************************
  // model updated at the falling edge where all signals are settled
  // **********************************************************************

  task automatic observe();
    logic w_fire;
    logic push_now;
    check("done", done, done_exp);
    check("resp_err", resp_err, err_exp);
    check("overflow", overflow, ovf_exp);
    if (burst_open) check("awvalid", awvalid, 1'b0);
    if (!wvalid) check("wlast", wlast, 1'b0);
    w_fire   = wvalid && wready;
    push_now = push_next;
    push_next = 1'b0;
    done_exp  = 1'b0;
    if (awvalid && awready) begin
      check("awaddr", awaddr, exp_addr);
      cur_addr   = awaddr;
      burst_open = 1'b1;
      beat_idx   = 0;
    end
    if (w_fire) begin
      if (exp_q.size() == 0) report("write beat with no expected data left");
      else check("wdata", wdata, exp_q.pop_front());
      check("wlast", wlast, beat_idx == `CAP_BURST_LEN - 1);
      mem[cur_addr + 32'(beat_idx * BEAT_BYTES)] = wdata;
      beat_idx++;
      beats_written++;
      if (beats_written % `CAP_FRAME_BEATS == 0) done_exp = 1'b1;
      if (beat_idx == `CAP_BURST_LEN) begin
        b_pending = 1'b1;
        b_delay   = int'(lcg_next() % 4);
      end
    end
    if (bvalid && bready) begin
      if (bresp != 2'b00) err_exp = 1'b1;
      if (exp_addr + BURST_BYTES >= `CAP_END_ADDR) exp_addr = `CAP_BASE_ADDR;
      else exp_addr = exp_addr + BURST_BYTES;
      burst_open = 1'b0;
      b_seen     = 1'b1;
      bursts_done++;
    end
    // full is judged on the count before this edge's pop
    if (push_now) begin
      if (fifo_cnt == `CAP_FIFO_DEPTH) begin
        ovf_exp = 1'b1;
        drops++;
      end else begin
        exp_q.push_back(pend_beat);
        kept_q.push_back(pend_beat);
        fifo_cnt++;
      end
    end
    if (w_fire) fifo_cnt--;
    // four samples per beat with lane 0 in the low bits
    if (sample_valid) begin
      part_beat[lane*`CAP_SAMPLE_W +: `CAP_SAMPLE_W] = sample_data;
      if (lane == `CAP_LANES - 1) begin
        pend_beat = part_beat;
        push_next = 1'b1;
        lane = 0;
      end else begin
        lane++;
      end
    end
  endtask

  // one clock with inputs driven 1 ns after the rising edge
  task automatic step();
    sample_valid = (send_mode == 2) || (send_mode == 1 && (lcg_next() % 2) == 0);
    if (sample_valid) sample_data = lcg_next();
    awready = (lcg_next() % 4) != 0;
    wready  = !hold_w && ((lcg_next() % 4) != 0);
    if (b_seen) begin
      bvalid = 1'b0;
      b_seen = 1'b0;
    end else if (b_pending) begin
      if (b_delay == 0) begin
        bvalid    = 1'b1;
        bresp     = (bursts_done == err_burst) ? 2'b10 : 2'b00;
        b_pending = 1'b0;
      end else begin
        b_delay--;
      end
    end
    @(negedge clk);
    observe();
    @(posedge clk);
    #1;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    rst_n = 1'b0;
    {sample_valid, awready, wready, bvalid, bresp} = '0;
    exp_q.delete();
    kept_q.delete();
    mem.delete();
    {lane, fifo_cnt, beat_idx, beats_written, bursts_done, drops, b_delay} = '0;
    {push_next, burst_open, b_pending, b_seen, done_exp, err_exp, ovf_exp} = '0;
    exp_addr = `CAP_BASE_ADDR;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
  endtask

  // run until no whole burst is left in the FIFO and the bus is quiet
  task automatic drain();
    int i;
    for (i = 0; i < 4000; i++) begin
      if (fifo_cnt < `CAP_BURST_LEN && !burst_open && !push_next) break;
      step();
    end
    if (i == 4000) report("timeout while draining the FIFO");
    repeat (4) step();
  endtask

  // **********************************************************************
  // test sequence
  // **********************************************************************

  initial begin
    int start_errs;
    int i;
    rst_n = 1'b0;
    sample_valid = 1'b0;
    sample_data = '0;
    {awready, wready, bvalid, bresp} = '0;
    {send_mode, hold_w, err_burst} = '0;
    lcg_state = 32'd39;
    {errors, tests_run, tests_failed} = '0;
    apply_reset();

    // random stream with stalls and one SLVERR
    start_errs = errors;
    err_burst  = 20 + int'(lcg_next() % 16);
    send_mode  = 1;
    for (i = 0; i < 40000 && bursts_done < 40; i++) step();
    if (bursts_done < 40) report("timeout waiting for 40 bursts");
    send_mode = 0;
    drain();
    if (!err_exp) report("no error response reached the writer");
    finish_test("burst_stream", start_errs);

    start_errs = errors;
    err_burst  = -1;
    apply_reset();
    check("resp_err", resp_err, 1'b0);
    check("overflow", overflow, 1'b0);
    check("awvalid", awvalid, 1'b0);
    check("wvalid", wvalid, 1'b0);
    check("done", done, 1'b0);
    check("bready", bready, 1'b1);
    finish_test("reset_clear", start_errs);

    // stall the W channel while samples keep coming
    start_errs = errors;
    hold_w    = 1'b1;
    send_mode = 2;
    repeat (OVF_BEATS * `CAP_LANES) step();
    send_mode = 0;
    hold_w    = 1'b0;
    drain();
    check("overflow", overflow, 1'b1);
    check("beats_written", beats_written, OVF_BEATS - drops);
    // kept beats sit in order from the base address
    for (i = 0; i < kept_q.size(); i++) begin
      check("mem", mem[`CAP_BASE_ADDR + 32'(i * BEAT_BYTES)], kept_q[i]);
    end
    finish_test("overflow", start_errs);

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* logic/capture_top.sv */
`timescale 1ns/1ps
`include "capture_consts.svh"

module capture_top
  import capture_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  // sample stream
  input  logic                     sample_valid,
  input  logic [`CAP_SAMPLE_W-1:0] sample_data,
  // AXI4 write address
  output logic                     awvalid,
  output logic [`CAP_ADDR_W-1:0]   awaddr,
  input  logic                     awready,
  // AXI4 write data
  output logic                     wvalid,
  output logic                     wlast,
  output logic [`CAP_BEAT_W-1:0]   wdata,
  input  logic                     wready,
  // AXI4 write response
  input  logic                     bvalid,
  input  logic [1:0]               bresp,
  output logic                     bready,
  // status
  output logic                     done,
  output logic                     resp_err,
  output logic                     overflow
);

  logic                  push_valid;
  beat_u                 push_beat;
  logic                  fifo_full;
  logic                  fifo_empty;
  logic [`CAP_CNT_W-1:0] fifo_count;
  logic                  fifo_pop;
  beat_u                 head_beat;

  // **********************************************************************
  // producer, buffer, consumer
  // **********************************************************************

  sample_packer u_sample_packer (
    .clk          (clk),
    .rst_n        (rst_n),
    .sample_valid (sample_valid),
    .sample_data  (sample_data),
    .full         (fifo_full),
    .push_valid   (push_valid),
    .push_beat    (push_beat),
    .overflow     (overflow)
  );

  beat_fifo u_beat_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (push_valid),
    .push_beat  (push_beat),
    .pop        (fifo_pop),
    .head_beat  (head_beat),
    .empty      (fifo_empty),
    .full       (fifo_full),
    .count      (fifo_count)
  );

  axi_burst_writer u_axi_burst_writer (
    .clk       (clk),
    .rst_n     (rst_n),
    .head_beat (head_beat),
    .empty     (fifo_empty),
    .count     (fifo_count),
    .pop       (fifo_pop),
    .awvalid   (awvalid),
    .awaddr    (awaddr),
    .awready   (awready),
    .wvalid    (wvalid),
    .wlast     (wlast),
    .wdata     (wdata),
    .wready    (wready),
    .bvalid    (bvalid),
    .bresp     (bresp),
    .bready    (bready),
    .done      (done),
    .resp_err  (resp_err)
  );

endmodule

/* logic/axi_burst_writer.sv */
`timescale 1ns/1ps
`include "capture_consts.svh"

module axi_burst_writer
  import capture_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  beat_u                  head_beat,
  input  logic                   empty,
  input  logic [`CAP_CNT_W-1:0]  count,
  output logic                   pop,
  output logic                   awvalid,
  output logic [`CAP_ADDR_W-1:0] awaddr,
  input  logic                   awready,
  output logic                   wvalid,
  output logic                   wlast,
  output logic [`CAP_BEAT_W-1:0] wdata,
  input  logic                   wready,
  input  logic                   bvalid,
  input  logic [1:0]             bresp,
  output logic                   bready,
  output logic                   done,
  output logic                   resp_err
);

  localparam int BEAT_CNT_W  = $clog2(`CAP_BURST_LEN);
  localparam int FRAME_CNT_W = $clog2(`CAP_FRAME_BEATS);
  localparam int BURST_BYTES = `CAP_BURST_LEN * (`CAP_BEAT_W / 8);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_DATA = 2'd1;
  localparam logic [1:0] ST_RESP = 2'd2;

  logic [1:0]             state;
  logic [BEAT_CNT_W-1:0]  beat_cnt;
  logic [FRAME_CNT_W-1:0] frame_cnt;
  logic [`CAP_ADDR_W-1:0] next_addr;
  logic                   burst_ready;
  logic                   aw_fire;
  logic                   w_fire;
  logic                   b_fire;

  // a whole burst sits in the buffer
  assign burst_ready = !empty && (count >= `CAP_CNT_W'(`CAP_BURST_LEN));

  assign aw_fire = awvalid && awready;
  assign w_fire  = wvalid && wready;
  assign b_fire  = bvalid && bready;

  // data goes straight from the FIFO head onto the bus
  assign wdata = head_beat.raw;
  assign pop   = w_fire;
  assign wlast = wvalid && (beat_cnt == BEAT_CNT_W'(`CAP_BURST_LEN - 1));

  // one burst in flight, so responses are always accepted
  assign bready = 1'b1;

  // **********************************************************************
  // channel FSM
  // **********************************************************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      awvalid  <= 1'b0;
      wvalid   <= 1'b0;
      beat_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (aw_fire) begin
            awvalid <= 1'b0;
            wvalid  <= 1'b1;
            state   <= ST_DATA;
          end else if (!awvalid && burst_ready) begin
            awvalid <= 1'b1;
          end
        end
        ST_DATA: begin
          if (w_fire) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (wlast) begin
              wvalid   <= 1'b0;
              beat_cnt <= '0;
              state    <= ST_RESP;
            end
          end
        end
        ST_RESP: begin
          if (b_fire) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // **********************************************************************
  // address, frame count, response status
  // **********************************************************************

  assign next_addr = awaddr + `CAP_ADDR_W'(BURST_BYTES);

  // address moves on only once the burst is acknowledged
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      awaddr <= `CAP_BASE_ADDR;
    end else if (b_fire) begin
      if (next_addr >= `CAP_END_ADDR) begin
        awaddr <= `CAP_BASE_ADDR;
      end else begin
        awaddr <= next_addr;
      end
    end
  end

  // done follows the beat that closes a frame
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frame_cnt <= '0;
      done      <= 1'b0;
    end else begin
      done <= w_fire && (frame_cnt == FRAME_CNT_W'(`CAP_FRAME_BEATS - 1));
      if (w_fire) begin
        frame_cnt <= frame_cnt + 1'b1;
      end
    end
  end

  // sticky on any response other than OKAY
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_err <= 1'b0;
    end else if (b_fire && (bresp != 2'b00)) begin
      resp_err <= 1'b1;
    end
  end

endmodule

/* logic/beat_fifo.sv */
`timescale 1ns/1ps
`include "capture_consts.svh"

module beat_fifo
  import capture_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  push_valid,
  input  beat_u                 push_beat,
  input  logic                  pop,
  output beat_u                 head_beat,
  output logic                  empty,
  output logic                  full,
  output logic [`CAP_CNT_W-1:0] count
);

  // depth is a power of two, so pointers wrap on their own
  localparam int PTR_W = $clog2(`CAP_FIFO_DEPTH);

  beat_u            mem [`CAP_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             do_push;
  logic             do_pop;

  assign do_push = push_valid && !full;
  assign do_pop  = pop && !empty;

  // **********************************************************************
  // storage
  // **********************************************************************

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_beat;
    end
  end

  // first word fall through, oldest entry always on the output
  assign head_beat = mem[rd_ptr];

  // **********************************************************************
  // pointers and occupancy
  // **********************************************************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves count alone
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign empty = (count == '0);
  assign full  = (count == `CAP_CNT_W'(`CAP_FIFO_DEPTH));

endmodule

/* logic/sample_packer.sv */
`timescale 1ns/1ps
`include "capture_consts.svh"

module sample_packer
  import capture_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      sample_valid,
  input  logic [`CAP_SAMPLE_W-1:0]  sample_data,
  input  logic                      full,
  output logic                      push_valid,
  output beat_u                     push_beat,
  output logic                      overflow
);

  localparam int LANE_IDX_W = $clog2(`CAP_LANES);

  logic [LANE_IDX_W-1:0] lane_idx;
  logic                  last_lane;
  beat_u                 build_beat;
  beat_u                 next_beat;

  assign last_lane = (lane_idx == LANE_IDX_W'(`CAP_LANES - 1));

  // beat under construction with the current sample dropped into its lane
  always_comb begin
    next_beat = build_beat;
    next_beat.lane[lane_idx] = sample_data;
  end

  // lane index and push strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lane_idx   <= '0;
      push_valid <= 1'b0;
    end else begin
      push_valid <= sample_valid && last_lane;
      if (sample_valid) begin
        lane_idx <= lane_idx + 1'b1;
      end
    end
  end

  // beat payload
  always_ff @(posedge clk) begin
    if (sample_valid) begin
      build_beat <= next_beat;
      if (last_lane) begin
        push_beat <= next_beat;
      end
    end
  end

  // a beat pushed into a full buffer is lost and flagged until reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      overflow <= 1'b0;
    end else if (push_valid && full) begin
      overflow <= 1'b1;
    end
  end

endmodule

/* logic/capture_pkg.sv */
`include "capture_consts.svh"

package capture_pkg;

  // **********************************************************************
  // one buffered beat, seen two ways
  // **********************************************************************

  // raw is what the FIFO stores and the bus carries,
  // lane is how the packer fills it
  // lane[0] sits in bits 31:0 and holds the oldest sample
  typedef union packed {
    logic [`CAP_BEAT_W-1:0]                    raw;
    logic [`CAP_LANES-1:0][`CAP_SAMPLE_W-1:0]  lane;
  } beat_u;

endpackage

/* logic/capture_consts.svh */
`ifndef CAPTURE_CONSTS_SVH
`define CAPTURE_CONSTS_SVH

// sample and beat geometry
`define CAP_SAMPLE_W    32
`define CAP_LANES       4
`define CAP_BEAT_W      128

// burst shape, beats of 16 bytes each
`define CAP_BURST_LEN   8

// beat buffer
`define CAP_FIFO_DEPTH  32
`define CAP_CNT_W       6

// address window, 32 bursts of 128 bytes
`define CAP_ADDR_W      32
`define CAP_BASE_ADDR   32'h0000_0000
`define CAP_END_ADDR    32'h0000_1000

// beats per done pulse
`define CAP_FRAME_BEATS 64

`endif
